// File: all.f
+incdir+rtl
rtl/spis_pkg.sv
rtl/spis_fifo_if.sv
rtl/spis_csr_if.sv
rtl/spis_sync_fifo.sv
rtl/spis_access_ctrl.sv
rtl/spis_csr.sv
rtl/spis_reg_top.sv
tests/spis_asserts.sv
tests/spis_tb.sv

// File: rtl/spis_access_ctrl.sv
`include "spis_defines.svh"

module spis_access_ctrl (
	input  logic                      s_avmm_clk,
	input  logic                      s_avmm_rst_n,
	// spi side, already deserialized
	input  logic                      spi_write,
	input  logic                      spi_read,
	input  logic [`SPIS_ADDR_W-1:0]   spi_addr,
	input  logic [`SPIS_DATA_W-1:0]   mosi_data,
	output logic [`SPIS_DATA_W-1:0]   miso_data,
	// avalon side
	input  logic                      avb2reg_write,
	input  logic                      avb2reg_read,
	input  logic [`SPIS_ADDR_W-1:0]   avb2reg_addr,
	input  logic [`SPIS_DATA_W-1:0]   avb2reg_rdata,
	output logic [`SPIS_DATA_W-1:0]   reg2avb_wdata,
	spis_fifo_if.ctrl                 wbuf,
	spis_fifo_if.ctrl                 rbuf,
	spis_csr_if.ctrl                  csr,
	output logic                      wbuf_ovf,
	output logic                      wbuf_udf,
	output logic                      rbuf_ovf,
	output logic                      rbuf_udf
);

	import spis_pkg::*;

	spis_region_e spi_region;
	spis_region_e avb_region;
	spis_reg_e    spi_reg;
	logic         spi_wbuf_wr;
	logic         spi_rbuf_rd;
	logic         avb_rbuf_wr;
	logic         avb_wbuf_rd;

	function automatic spis_region_e region_of(input logic [`SPIS_ADDR_W-1:0] addr);
		if (addr < `SPIS_WBUF_LO)
			return REGION_REG;
		else if (addr <= `SPIS_WBUF_HI)
			return REGION_WBUF;
		else if (addr >= `SPIS_RBUF_LO && addr <= `SPIS_RBUF_HI)
			return REGION_RBUF;
		return REGION_NONE;
	endfunction

	function automatic spis_reg_e reg_of(input logic [`SPIS_ADDR_W-1:0] addr);
		case (addr)
			`SPIS_REG_CMD:    return REG_CMD;
			`SPIS_REG_STATUS: return REG_STATUS;
			`SPIS_REG_DIAG0:  return REG_DIAG0;
			`SPIS_REG_DIAG1:  return REG_DIAG1;
			`SPIS_REG_CTRL:   return REG_CTRL;
			default:          return REG_NONE;
		endcase
	endfunction

	//////////////////////////////
	// decode
	//////////////////////////////

	assign spi_region = region_of(spi_addr);
	assign avb_region = region_of(avb2reg_addr);
	assign spi_reg    = (spi_region == REGION_REG) ? reg_of(spi_addr) : REG_NONE;

	assign spi_wbuf_wr = spi_write && (spi_region == REGION_WBUF);
	assign spi_rbuf_rd = spi_read && (spi_region == REGION_RBUF);
	assign avb_rbuf_wr = avb2reg_write && (avb_region == REGION_RBUF);  // other windows ignored
	assign avb_wbuf_rd = avb2reg_read && (avb_region == REGION_WBUF);

	// buffer strobes, gated so the fifo never sees a bad push/pop
	assign wbuf.push   = spi_wbuf_wr && !wbuf.full;
	assign wbuf.wrdata = mosi_data;
	assign wbuf.pop    = avb_wbuf_rd && !wbuf.empty;
	assign rbuf.push   = avb_rbuf_wr && !rbuf.full;
	assign rbuf.wrdata = avb2reg_rdata;
	assign rbuf.pop    = spi_rbuf_rd && !rbuf.empty;

	// dropped accesses become error pulses
	assign wbuf_ovf = spi_wbuf_wr && wbuf.full;
	assign wbuf_udf = avb_wbuf_rd && wbuf.empty;
	assign rbuf_ovf = avb_rbuf_wr && rbuf.full;
	assign rbuf_udf = spi_rbuf_rd && rbuf.empty;

	assign csr.wr    = spi_write && (spi_region == REGION_REG);
	assign csr.rd    = spi_read && (spi_region == REGION_REG);
	assign csr.sel   = spi_reg;
	assign csr.wdata = mosi_data;

	//////////////////////////////
	// read data, held until next read
	//////////////////////////////

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			miso_data     <= '0;
			reg2avb_wdata <= '0;
		end else begin
			if (spi_read) begin
				case (spi_region)
					REGION_RBUF: miso_data <= rbuf.empty ? '0 : rbuf.rddata;
					REGION_REG:  miso_data <= (spi_reg == REG_NONE) ? `SPIS_UNMAPPED : csr.rdata;
					default:     miso_data <= `SPIS_UNMAPPED;   // wbuf is write only from spi
				endcase
			end
			if (avb_wbuf_rd)
				reg2avb_wdata <= wbuf.empty ? '0 : wbuf.rddata;
		end
	end

endmodule

// File: rtl/spis_csr.sv
`include "spis_defines.svh"

module spis_csr (
	input  logic                      s_avmm_clk,
	input  logic                      s_avmm_rst_n,
	spis_csr_if.csr                   csr,
	// error pulses from the access controller
	input  logic                      wbuf_ovf,
	input  logic                      wbuf_udf,
	input  logic                      rbuf_ovf,
	input  logic                      rbuf_udf,
	input  logic [`SPIS_CNT_W-1:0]    wbuf_cnt,
	input  logic [`SPIS_CNT_W-1:0]    rbuf_cnt,
	// capture triggers and debug buses
	input  logic                      ssn_off,
	input  logic                      avmmtransvld_up,
	input  logic [`SPIS_DATA_W-1:0]   dbg_bus0,
	input  logic [`SPIS_DATA_W-1:0]   dbg_bus1,
	// avalon transaction request
	output logic [7:0]                avmm_brstlen,
	output logic [1:0]                avmm_sel,
	output logic [16:0]               avmm_offset,
	output logic                      avmm_rdnwr,
	output logic                      avmm_transvld,
	output logic                      wbuf_flush,
	output logic                      rbuf_flush
);

	import spis_pkg::*;

	logic                    cmd_wr;
	logic                    ctrl_wr;
	logic [3:0]              err;
	logic [3:0]              clr;
	logic [3:0]              flags;      // wbuf_ovf, wbuf_udf, rbuf_ovf, rbuf_udf
	logic [`SPIS_DATA_W-1:0] diag0;
	logic [`SPIS_DATA_W-1:0] diag1;
	logic [`SPIS_DATA_W-1:0] cmd_word;
	logic [`SPIS_DATA_W-1:0] status_word;
	logic [`SPIS_DATA_W-1:0] rdata_mux;

	assign cmd_wr  = csr.wr && (csr.sel == REG_CMD);
	assign ctrl_wr = csr.wr && (csr.sel == REG_CTRL);

	//////////////////////////////
	// command register
	//////////////////////////////

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			avmm_brstlen  <= '0;
			avmm_sel      <= '0;
			avmm_offset   <= '0;
			avmm_rdnwr    <= 1'b0;
			avmm_transvld <= 1'b0;
		end else begin
			if (cmd_wr) begin
				avmm_brstlen <= csr.wdata[31:24];
				avmm_sel     <= csr.wdata[20:19];
				avmm_offset  <= csr.wdata[18:2];
				avmm_rdnwr   <= csr.wdata[1];
			end
			if (avmmtransvld_up)
				avmm_transvld <= 1'b0;     // transaction done, beats a new write
			else if (cmd_wr)
				avmm_transvld <= csr.wdata[0];
		end
	end

	assign cmd_word = {avmm_brstlen, 3'b000, avmm_sel, avmm_offset, avmm_rdnwr, avmm_transvld};

	//////////////////////////////
	// sticky flags and control
	//////////////////////////////

	assign err = {wbuf_ovf, wbuf_udf, rbuf_ovf, rbuf_udf};
	assign clr = ctrl_wr ? csr.wdata[3:0] : 4'b0000;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			flags <= '0;
		else
			flags <= (flags & ~clr) | err;    // new error wins over clear
	end

	// flush strobes live for the write cycle only
	assign wbuf_flush = ctrl_wr && csr.wdata[4];
	assign rbuf_flush = ctrl_wr && csr.wdata[5];

	// debug captures
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			diag0 <= '0;
			diag1 <= '0;
		end else begin
			if (ssn_off)
				diag0 <= dbg_bus0;
			if (avmmtransvld_up)
				diag1 <= dbg_bus1;
		end
	end

	//////////////////////////////
	// read mux
	//////////////////////////////

	always_comb begin
		status_word        = '0;
		status_word[3:0]   = flags;
		status_word[12:8]  = wbuf_cnt;
		status_word[20:16] = rbuf_cnt;
	end

	always_comb begin
		rdata_mux = '0;
		if (csr.rd) begin
			case (csr.sel)
				REG_CMD:    rdata_mux = cmd_word;
				REG_STATUS: rdata_mux = status_word;
				REG_DIAG0:  rdata_mux = diag0;
				REG_DIAG1:  rdata_mux = diag1;
				default:    rdata_mux = '0;     // ctrl reads back as zero
			endcase
		end
	end

	assign csr.rdata = rdata_mux;

endmodule

// File: rtl/spis_csr_if.sv
`include "spis_defines.svh"

// register access path, access controller to register file
interface spis_csr_if;

	import spis_pkg::*;

	logic                      wr;
	logic                      rd;
	spis_reg_e                 sel;
	logic [`SPIS_DATA_W-1:0]   wdata;
	logic [`SPIS_DATA_W-1:0]   rdata;      // combinational for current sel

	modport ctrl (
		output wr, rd, sel, wdata,
		input  rdata
	);

	modport csr (
		input  wr, rd, sel, wdata,
		output rdata
	);

endinterface

// File: rtl/spis_defines.svh
`ifndef SPIS_DEFINES_SVH
`define SPIS_DEFINES_SVH

// datapath widths
`define SPIS_DATA_W      32
`define SPIS_ADDR_W      16

//////////////////////////////
// buffer sizing
//////////////////////////////
`define SPIS_FIFO_DEPTH  16
`define SPIS_CNT_W       5       // log2(depth) + 1

// spi side address windows
`define SPIS_WBUF_LO     16'h0200
`define SPIS_WBUF_HI     16'h09FF
`define SPIS_RBUF_LO     16'h1000
`define SPIS_RBUF_HI     16'h17FF

`define SPIS_UNMAPPED    32'hDEADBEEF    // returned for holes in the map

//////////////////////////////
// register offsets
//////////////////////////////
`define SPIS_REG_CMD     16'h0000
`define SPIS_REG_STATUS  16'h0004
`define SPIS_REG_DIAG0   16'h0008
`define SPIS_REG_DIAG1   16'h000C
`define SPIS_REG_CTRL    16'h0010

`endif

// File: rtl/spis_fifo_if.sv
`include "spis_defines.svh"

// one buffer: producer/consumer strobes on one side, storage on the other
interface spis_fifo_if;

	logic                      push;
	logic [`SPIS_DATA_W-1:0]   wrdata;
	logic                      pop;
	logic                      flush;      // from the control register
	logic [`SPIS_DATA_W-1:0]   rddata;     // head word, show-ahead
	logic                      full;
	logic                      empty;
	logic [`SPIS_CNT_W-1:0]    numfilled;

	// access controller side
	modport ctrl (
		output push, wrdata, pop,
		input  rddata, full, empty, numfilled
	);

	// storage side
	modport fifo (
		input  push, wrdata, pop, flush,
		output rddata, full, empty, numfilled
	);

endinterface

// File: rtl/spis_pkg.sv
package spis_pkg;

	//////////////////////////////
	// address decode
	//////////////////////////////

	// where an spi or avalon address lands
	typedef enum logic [1:0] {
		REGION_REG  = 2'd0,    // below the write buffer window
		REGION_WBUF = 2'd1,
		REGION_RBUF = 2'd2,
		REGION_NONE = 2'd3
	} spis_region_e;

	//////////////////////////////
	// register file select
	//////////////////////////////

	typedef enum logic [2:0] {
		REG_CMD    = 3'd0,
		REG_STATUS = 3'd1,
		REG_DIAG0  = 3'd2,
		REG_DIAG1  = 3'd3,
		REG_CTRL   = 3'd4,     // write only
		REG_NONE   = 3'd7      // offset not in the register map
	} spis_reg_e;

endpackage

// File: rtl/spis_reg_top.sv
`include "spis_defines.svh"

module spis_reg_top (
	input  logic                      s_avmm_clk,
	input  logic                      s_avmm_rst_n,
	// spi word strobes
	input  logic                      spi_write,
	input  logic                      spi_read,
	input  logic [`SPIS_ADDR_W-1:0]   spi_addr,
	input  logic [`SPIS_DATA_W-1:0]   mosi_data,
	output logic [`SPIS_DATA_W-1:0]   miso_data,
	// avalon bridge
	input  logic                      avb2reg_write,
	input  logic                      avb2reg_read,
	input  logic [`SPIS_ADDR_W-1:0]   avb2reg_addr,
	input  logic [`SPIS_DATA_W-1:0]   avb2reg_rdata,
	output logic [`SPIS_DATA_W-1:0]   reg2avb_wdata,
	output logic [7:0]                avmm_brstlen,
	output logic [1:0]                avmm_sel,
	output logic [16:0]               avmm_offset,
	output logic                      avmm_rdnwr,
	output logic                      avmm_transvld,
	input  logic                      avmmtransvld_up,
	// debug capture
	input  logic                      ssn_off,
	input  logic [`SPIS_DATA_W-1:0]   dbg_bus0,
	input  logic [`SPIS_DATA_W-1:0]   dbg_bus1
);

	logic wbuf_ovf;
	logic wbuf_udf;
	logic rbuf_ovf;
	logic rbuf_udf;

	spis_fifo_if wbuf_if ();    // spi -> avalon
	spis_fifo_if rbuf_if ();    // avalon -> spi
	spis_csr_if  csr_if ();

	spis_sync_fifo #(.DEPTH(`SPIS_FIFO_DEPTH)) u_wbuf (
		.s_avmm_clk, .s_avmm_rst_n, .fifo(wbuf_if.fifo)
	);

	spis_sync_fifo #(.DEPTH(`SPIS_FIFO_DEPTH)) u_rbuf (
		.s_avmm_clk, .s_avmm_rst_n, .fifo(rbuf_if.fifo)
	);

	spis_access_ctrl u_ctrl (
		.s_avmm_clk, .s_avmm_rst_n,
		.spi_write, .spi_read, .spi_addr, .mosi_data, .miso_data,
		.avb2reg_write, .avb2reg_read, .avb2reg_addr, .avb2reg_rdata, .reg2avb_wdata,
		.wbuf(wbuf_if.ctrl), .rbuf(rbuf_if.ctrl), .csr(csr_if.ctrl),
		.wbuf_ovf, .wbuf_udf, .rbuf_ovf, .rbuf_udf
	);

	spis_csr u_csr (
		.s_avmm_clk, .s_avmm_rst_n, .csr(csr_if.csr),
		.wbuf_ovf, .wbuf_udf, .rbuf_ovf, .rbuf_udf,
		.wbuf_cnt(wbuf_if.numfilled), .rbuf_cnt(rbuf_if.numfilled),
		.ssn_off, .avmmtransvld_up, .dbg_bus0, .dbg_bus1,
		.avmm_brstlen, .avmm_sel, .avmm_offset, .avmm_rdnwr, .avmm_transvld,
		.wbuf_flush(wbuf_if.flush),     // flush strobes into the buffers
		.rbuf_flush(rbuf_if.flush)
	);

endmodule

// File: rtl/spis_sync_fifo.sv
`include "spis_defines.svh"

module spis_sync_fifo #(
	parameter int DEPTH = `SPIS_FIFO_DEPTH    // power of two
) (
	input  logic       s_avmm_clk,
	input  logic       s_avmm_rst_n,
	spis_fifo_if.fifo  fifo
);

	localparam int AW = $clog2(DEPTH);

	logic [`SPIS_DATA_W-1:0] mem [0:DEPTH-1];

	// extra msb tells a wrapped full buffer from an empty one
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] fill;

	//////////////////////////////
	// pointers
	//////////////////////////////

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (fifo.flush) begin
			// flush beats any push or pop this cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (fifo.push)
				wr_ptr <= wr_ptr + 1'b1;
			if (fifo.pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// strobes come pre-gated with full/empty from the controller
	always_ff @(posedge s_avmm_clk) begin
		if (fifo.push && !fifo.flush)
			mem[wr_ptr[AW-1:0]] <= fifo.wrdata;
	end

	//////////////////////////////
	// status
	//////////////////////////////

	assign fill = wr_ptr - rd_ptr;

	assign fifo.empty = (wr_ptr == rd_ptr);
	assign fifo.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign fifo.numfilled = `SPIS_CNT_W'(fill);

	// show-ahead, head word always visible
	assign fifo.rddata = mem[rd_ptr[AW-1:0]];

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the spi slave register block testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module spis_tb -f all.f -o spis_sim
./obj_dir/spis_sim +verilator+error+limit+1000 2>&1 | tee sim.log
if grep -q "^TESTBENCH PASSED$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: tests/spis_asserts.sv
`include "spis_defines.svh"

module spis_asserts (
	input logic                    s_avmm_clk,
	input logic                    s_avmm_rst_n,
	input logic                    spi_write,
	input logic                    spi_read,
	input logic [`SPIS_ADDR_W-1:0] spi_addr,
	input logic [`SPIS_DATA_W-1:0] mosi_data,
	input logic [`SPIS_DATA_W-1:0] miso_data,
	input logic [`SPIS_DATA_W-1:0] reg2avb_wdata,
	input logic [7:0]              avmm_brstlen,
	input logic [1:0]              avmm_sel,
	input logic [16:0]             avmm_offset,
	input logic                    avmm_rdnwr,
	input logic                    avmm_transvld,
	input logic                    avmmtransvld_up
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fails = 0;    // failed checks so far
	logic        cmd_wr;
	logic        spi_hole;

	assign cmd_wr = spi_write && (spi_addr == `SPIS_REG_CMD);

	// above the write window and outside the read window
	assign spi_hole = (spi_addr > `SPIS_WBUF_HI) &&
		!((spi_addr >= `SPIS_RBUF_LO) && (spi_addr <= `SPIS_RBUF_HI));

	//////////////////////////////
	// command register
	//////////////////////////////

	a_cmd_fields: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		cmd_wr |=> (avmm_brstlen == $past(mosi_data[31:24])) &&
			(avmm_sel == $past(mosi_data[20:19])) &&
			(avmm_offset == $past(mosi_data[18:2])) &&
			(avmm_rdnwr == $past(mosi_data[1])))
		else begin
			$error("avmm command fields do not match the written command word");
			fails++;
		end

	a_transvld_set: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		cmd_wr && !avmmtransvld_up |=> avmm_transvld == $past(mosi_data[0]))
		else begin
			$error("avmm_transvld does not follow command bit 0");
			fails++;
		end

	// transaction done drops the request one edge later
	a_transvld_drop: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		avmmtransvld_up |=> !avmm_transvld)
		else begin
			$error("avmm_transvld still high after avmmtransvld_up");
			fails++;
		end

	a_unmapped_read: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		spi_read && spi_hole |=> miso_data == `SPIS_UNMAPPED)
		else begin
			$error("unmapped spi read did not return the unmapped pattern");
			fails++;
		end

	a_reset_values: assert property (@(posedge s_avmm_clk)
		$rose(s_avmm_rst_n) |-> (miso_data == '0) && (reg2avb_wdata == '0) && !avmm_transvld)
		else begin
			$error("outputs not cleared by reset");
			fails++;
		end

endmodule

// File: tests/spis_tb.sv
`include "spis_defines.svh"

module spis_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int POLL_LIMIT = 20;

	logic                    s_avmm_clk = 1'b0;
	logic                    s_avmm_rst_n;
	logic                    spi_write, spi_read, avb2reg_write, avb2reg_read;
	logic                    avmmtransvld_up, ssn_off;
	logic [`SPIS_ADDR_W-1:0] spi_addr, avb2reg_addr;
	logic [`SPIS_DATA_W-1:0] mosi_data, avb2reg_rdata, dbg_bus0, dbg_bus1;
	logic [`SPIS_DATA_W-1:0] miso_data, reg2avb_wdata;
	logic [7:0]              avmm_brstlen;
	logic [1:0]              avmm_sel;
	logic [16:0]             avmm_offset;
	logic                    avmm_rdnwr, avmm_transvld;

	logic [`SPIS_DATA_W-1:0] wq[$];    // write buffer model
	logic [`SPIS_DATA_W-1:0] rq[$];    // read buffer model
	int errors = 0;
	int mark = 0;
	int passed = 0;
	int failed = 0;

	spis_reg_top DUT (.*);

	bind spis_reg_top spis_asserts u_asserts (.*);

	always #20 s_avmm_clk = ~s_avmm_clk;

	//////////////////////////////
	// bus helpers
	//////////////////////////////

	task automatic tick();
		@(posedge s_avmm_clk);
		#2;    // drive just after the edge
	endtask

	task automatic spi_wr(input logic [15:0] addr, input logic [31:0] data);
		spi_write = 1'b1;
		spi_addr  = addr;
		mosi_data = data;
		tick();
		spi_write = 1'b0;
	endtask

	task automatic spi_rd(input logic [15:0] addr, output logic [31:0] data);
		spi_read = 1'b1;
		spi_addr = addr;
		tick();
		spi_read = 1'b0;
		data     = miso_data;    // registered at the strobe edge
	endtask

	task automatic avb_wr(input logic [31:0] data);
		avb2reg_write = 1'b1;
		avb2reg_addr  = `SPIS_RBUF_LO;
		avb2reg_rdata = data;
		tick();
		avb2reg_write = 1'b0;
	endtask

	task automatic avb_rd(output logic [31:0] data);
		avb2reg_read = 1'b1;
		avb2reg_addr = `SPIS_WBUF_LO;
		tick();
		avb2reg_read = 1'b0;
		data         = reg2avb_wdata;
	endtask

	function automatic void compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endfunction

	// poll a fill count field of STATUS
	task automatic wait_count(input string name, input int lsb, input int exp);
		logic [31:0] st;
		int polls;
		polls = 0;
		spi_rd(`SPIS_REG_STATUS, st);
		while (int'(st[lsb +: `SPIS_CNT_W]) != exp) begin
			polls++;
			if (polls > POLL_LIMIT) begin
				$display("timeout: %s fill count never reached %0d", name, exp);
				$display("TESTBENCH FAILED");
				$finish;
			end
			spi_rd(`SPIS_REG_STATUS, st);
		end
	endtask

	task automatic close_test(input int num, input string name);
		int now_err;
		tick();
		tick();    // let the last assertions sample
		now_err = errors + int'(DUT.u_asserts.fails);
		if (now_err == mark) begin
			passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			failed++;
			$display("test %0d %s: fail, %0d errors", num, name, now_err - mark);
		end
		mark = now_err;
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		logic [31:0] d;
		logic [31:0] cmd;
		int i;

		void'($urandom(20));
		s_avmm_rst_n = 1'b0;
		{spi_write, spi_read, avb2reg_write, avb2reg_read, avmmtransvld_up, ssn_off} = '0;
		{spi_addr, avb2reg_addr} = '0;
		{mosi_data, avb2reg_rdata, dbg_bus0, dbg_bus1} = '0;
		repeat (4) @(posedge s_avmm_clk);
		#2;
		s_avmm_rst_n = 1'b1;
		tick();

		cmd = $urandom;
		cmd[23:21] = 3'b000;    // unused bits read as zero
		cmd[0] = 1'b1;
		spi_wr(`SPIS_REG_CMD, cmd);
		spi_rd(`SPIS_REG_CMD, d);
		compare_word("miso_data (CMD)", d, cmd);
		compare_word("avmm_transvld", {31'd0, avmm_transvld}, 32'd1);
		avmmtransvld_up = 1'b1;
		tick();
		avmmtransvld_up = 1'b0;
		spi_rd(`SPIS_REG_CMD, d);
		compare_word("miso_data (CMD after done)", d, {cmd[31:1], 1'b0});
		close_test(1, "command register");

		for (i = 0; i < 8; i++) begin
			d = $urandom;
			wq.push_back(d);
			spi_wr(`SPIS_WBUF_LO + 16'(4 * i), d);
		end
		wait_count("write buffer", 8, 8);
		for (i = 0; i < 8; i++) begin
			avb_rd(d);
			compare_word("reg2avb_wdata", d, wq.pop_front());
		end
		wait_count("write buffer", 8, 0);
		close_test(2, "write buffer path");

		for (i = 0; i < 6; i++) begin
			d = $urandom;
			rq.push_back(d);
			avb_wr(d);
		end
		for (i = 0; i < 6; i++) begin
			spi_rd(`SPIS_RBUF_LO, d);
			compare_word("miso_data", d, rq.pop_front());
		end
		close_test(3, "read buffer path");

		for (i = 0; i < 17; i++) begin
			d = $urandom;
			if (i < `SPIS_FIFO_DEPTH)
				wq.push_back(d);    // the last push is dropped
			spi_wr(`SPIS_WBUF_LO, d);
		end
		wait_count("write buffer", 8, `SPIS_FIFO_DEPTH);
		spi_rd(`SPIS_REG_STATUS, d);
		compare_word("miso_data (STATUS flags)", d & 32'hF, 32'h8);
		spi_rd(`SPIS_RBUF_LO, d);
		compare_word("miso_data (empty read buffer)", d, 32'h0);
		spi_rd(`SPIS_REG_STATUS, d);
		compare_word("miso_data (STATUS flags)", d & 32'hF, 32'h9);
		spi_wr(`SPIS_REG_CTRL, 32'h9);
		spi_rd(`SPIS_REG_STATUS, d);
		compare_word("miso_data (STATUS flags)", d & 32'hF, 32'h0);
		close_test(4, "overflow and underflow");

		for (i = 0; i < 10; i++) begin
			avb_rd(d);
			compare_word("reg2avb_wdata", d, wq.pop_front());
		end
		wait_count("write buffer", 8, 6);
		spi_wr(`SPIS_REG_CTRL, 32'h10);
		wq.delete();
		wait_count("write buffer", 8, 0);
		repeat (3) avb_wr($urandom);
		wait_count("read buffer", 16, 3);
		spi_wr(`SPIS_REG_CTRL, 32'h20);
		wait_count("read buffer", 16, 0);
		spi_rd(16'h0C00, d);    // gap between the windows
		compare_word("miso_data (unmapped)", d, `SPIS_UNMAPPED);
		cmd = $urandom;
		dbg_bus0 = cmd;
		ssn_off = 1'b1;
		tick();
		ssn_off = 1'b0;
		dbg_bus0 = ~cmd;
		spi_rd(`SPIS_REG_DIAG0, d);
		compare_word("miso_data (DIAG0)", d, cmd);
		cmd = $urandom;
		dbg_bus1 = cmd;
		avmmtransvld_up = 1'b1;
		tick();
		avmmtransvld_up = 1'b0;
		dbg_bus1 = ~cmd;
		spi_rd(`SPIS_REG_DIAG1, d);
		compare_word("miso_data (DIAG1)", d, cmd);
		close_test(5, "flush, unmapped and diagnostics");

		$display("tests passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
			passed, failed, errors, DUT.u_asserts.fails);
		if (failed == 0 && errors == 0 && DUT.u_asserts.fails == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
